/* mul_pkg.sv */
`default_nettype none

package mul_pkg;

  // Opcode of a multiply request
  // Each encoding picks the signedness of operand 1 and operand 2 on its own
  typedef enum logic [1:0] {
    MUL_UU = 2'b00,
    MUL_SS = 2'b01,
    MUL_SU = 2'b10,
    MUL_US = 2'b11
  } mul_op_e;

  // Sign flags decoded from the opcode
  // A clear flag means the operand is zero-extended
  typedef struct packed {
    logic op1_signed;
    logic op2_signed;
  } mul_sign_t;

  // Number of radix-4 Booth partial products for an even operand width
  // The extra row covers the two sign-extension bits of the multiplier
  function automatic int booth_row_count(input int mul_size);
    return mul_size / 2 + 1;
  endfunction

  // Width of the count of negative Booth rows
  // One bit more than the clog2 of the row count so that a full count still fits
  function automatic int booth_corr_width(input int mul_size);
    return $clog2(booth_row_count(mul_size)) + 1;
  endfunction

endpackage

`default_nettype wire

/* mul_operand_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_operand_stage
  import mul_pkg::*;
#(
  parameter int MUL_SIZE = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  advance,
  input  logic                  in_valid,
  input  logic [MUL_SIZE-1:0]   in_op1,
  input  logic [MUL_SIZE-1:0]   in_op2,
  input  mul_op_e               in_op,
  output logic [MUL_SIZE-1:0]   op1,
  output logic [MUL_SIZE-1:0]   op2,
  output mul_sign_t             sign,
  output logic                  s1_valid
);

  mul_sign_t sign_d;

  // Decode the opcode into one sign flag per operand
  // Operand 1 is the multiplicand and operand 2 the multiplier
  always_comb begin
    sign_d.op1_signed = 1'b0;
    sign_d.op2_signed = 1'b0;
    case (in_op)
      MUL_UU: begin
        sign_d.op1_signed = 1'b0;
        sign_d.op2_signed = 1'b0;
      end
      MUL_SS: begin
        sign_d.op1_signed = 1'b1;
        sign_d.op2_signed = 1'b1;
      end
      MUL_SU: begin
        sign_d.op1_signed = 1'b1;
        sign_d.op2_signed = 1'b0;
      end
      MUL_US: begin
        sign_d.op1_signed = 1'b0;
        sign_d.op2_signed = 1'b1;
      end
      default: ;
    endcase
  end

  // Stage valid follows the input valid whenever the pipeline moves
  // A load with in_valid low leaves the stage empty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= in_valid;
    end
  end

  // Operands and flags load on the same advance as the stage valid
  always_ff @(posedge clk) begin
    if (advance) begin
      op1  <= in_op1;
      op2  <= in_op2;
      sign <= sign_d;
    end
  end

  // A request stalled by the output side must be held unchanged by the producer
  a_hold_request: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !advance |=> in_valid && $stable(in_op) && $stable(in_op1) && $stable(in_op2));

endmodule

`default_nettype wire

/* booth4_op_generator.sv */
`timescale 1ns/10ps
`default_nettype none

module booth4_op_generator
  import mul_pkg::*;
#(
  parameter int MUL_SIZE = 32
) (
  input  logic [MUL_SIZE-1:0]                   op1,
  input  logic [MUL_SIZE-1:0]                   op2,
  input  mul_sign_t                             sign,
  output logic [2*MUL_SIZE-1:0]                 pp [booth_row_count(MUL_SIZE)],
  output logic [booth_corr_width(MUL_SIZE)-1:0] corr
);

  localparam int PW   = 2 * MUL_SIZE;
  localparam int ROWS = booth_row_count(MUL_SIZE);
  localparam int CW   = booth_corr_width(MUL_SIZE);

  logic                mcand_sign;
  logic                mplier_sign;
  logic [MUL_SIZE+2:0] mplier_ext;
  logic [PW-1:0]       mcand_ext;
  logic [ROWS-1:0]     neg_row;

  // An unsigned operand behaves as if its sign bit were zero
  assign mcand_sign  = sign.op1_signed & op1[MUL_SIZE-1];
  assign mplier_sign = sign.op2_signed & op2[MUL_SIZE-1];

  // Two sign bits on top make the row count work for unsigned operands too
  // The zero below bit 0 is the implicit neighbour of the first group
  assign mplier_ext = {{2{mplier_sign}}, op2, 1'b0};
  assign mcand_ext  = {{(PW - MUL_SIZE){mcand_sign}}, op1};

  for (genvar r = 0; r < ROWS; r++) begin : g_row
    logic [2:0]    grp;
    logic [PW-1:0] row_val;

    // Groups overlap by one bit and step by two
    assign grp = mplier_ext[2*r+2 -: 3];

    // Recoded digit times the multiplicand, weighted by four to the row index
    // Negative digits give the ones complement and owe a +1 at bit 0
    always_comb begin
      case (grp)
        3'b001, 3'b010: row_val = mcand_ext << (2 * r);
        3'b011:         row_val = mcand_ext << (2 * r + 1);
        3'b100:         row_val = ~(mcand_ext << (2 * r + 1));
        3'b101, 3'b110: row_val = ~(mcand_ext << (2 * r));
        default:        row_val = '0;
      endcase
    end

    assign pp[r] = row_val;

    // Digit is negative for 100, 101 and 110
    // The code 111 is minus zero and needs no correction
    assign neg_row[r] = grp[2] & ~(grp[1] & grp[0]);
  end

  // Every inverted row is one short of its twos complement
  // Their number is added back once as a single small operand
  always_comb begin
    corr = '0;
    for (int r = 0; r < ROWS; r++) begin
      corr = corr + CW'(neg_row[r]);
    end
  end

endmodule

`default_nettype wire

/* csa_tree_reducer.sv */
`timescale 1ns/10ps
`default_nettype none

module csa_tree_reducer
  import mul_pkg::*;
#(
  parameter int MUL_SIZE = 32
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  advance,
  input  logic                                  s1_valid,
  input  logic [2*MUL_SIZE-1:0]                 pp [booth_row_count(MUL_SIZE)],
  input  logic [booth_corr_width(MUL_SIZE)-1:0] corr,
  output logic [2*MUL_SIZE-1:0]                 sum,
  output logic [2*MUL_SIZE-1:0]                 carry,
  output logic                                  s2_valid
);

  // Operand count left after a number of 3:2 layers
  // Each full group of three becomes two and leftovers pass through
  function automatic int ops_after(input int n_ops, input int layers);
    int n;
    n = n_ops;
    for (int l = 0; l < layers; l++) begin
      if (n > 2) begin
        n = 2 * (n / 3) + n % 3;
      end
    end
    return n;
  endfunction

  // Number of layers until only sum and carry remain
  function automatic int layer_count(input int n_ops);
    int n;
    int k;
    n = n_ops;
    k = 0;
    while (n > 2) begin
      n = 2 * (n / 3) + n % 3;
      k++;
    end
    return k;
  endfunction

  localparam int PW     = 2 * MUL_SIZE;
  localparam int ROWS   = booth_row_count(MUL_SIZE);
  localparam int CW     = booth_corr_width(MUL_SIZE);
  localparam int N_OPS  = ROWS + 1;
  localparam int LAYERS = layer_count(N_OPS);

  // Operand vectors of every tree level where level 0 is the input set
  logic [PW-1:0] tree [LAYERS+1][N_OPS];

  for (genvar r = 0; r < ROWS; r++) begin : g_in
    assign tree[0][r] = pp[r];
  end
  // The correction count sits at bit 0 as the last operand
  assign tree[0][ROWS] = {{(PW - CW){1'b0}}, corr};

  for (genvar lay = 0; lay < LAYERS; lay++) begin : g_layer
    localparam int CNT    = ops_after(N_OPS, lay);
    localparam int GROUPS = CNT / 3;
    localparam int NEXT   = ops_after(N_OPS, lay + 1);

    // Bitwise full adders whose carries move one place up and drop off the top
    for (genvar g = 0; g < GROUPS; g++) begin : g_fa
      logic [PW-1:0] a;
      logic [PW-1:0] b;
      logic [PW-1:0] c;
      assign a = tree[lay][3*g];
      assign b = tree[lay][3*g+1];
      assign c = tree[lay][3*g+2];
      assign tree[lay+1][2*g]   = a ^ b ^ c;
      assign tree[lay+1][2*g+1] = ((a & b) | (a & c) | (b & c)) << 1;
    end

    // Up to two operands that do not fill a group go to the next level as they are
    for (genvar r = 3 * GROUPS; r < CNT; r++) begin : g_pass
      assign tree[lay+1][2*GROUPS+r-3*GROUPS] = tree[lay][r];
    end

    for (genvar r = NEXT; r < N_OPS; r++) begin : g_unused
      assign tree[lay+1][r] = '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else if (advance) begin
      s2_valid <= s1_valid;
    end
  end

  // Redundant form of the product that the output side resolves
  always_ff @(posedge clk) begin
    if (advance) begin
      sum   <= tree[LAYERS][0];
      carry <= tree[LAYERS][1];
    end
  end

endmodule

`default_nettype wire

/* mul_result_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_result_stage #(
  parameter int MUL_SIZE = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  s2_valid,
  input  logic [2*MUL_SIZE-1:0] sum,
  input  logic [2*MUL_SIZE-1:0] carry,
  input  logic                  out_ready,
  output logic                  out_valid,
  output logic [2*MUL_SIZE-1:0] out_product,
  output logic                  advance
);

  localparam int PW = 2 * MUL_SIZE;

  logic [PW-1:0] product_d;

  // The pipeline moves when the output register is free or being drained
  // All earlier stages follow the same decision, so nothing is dropped
  assign advance = ~out_valid | out_ready;

  // The final carry-propagate addition drops the carry out of the top bit
  assign product_d = sum + carry;

  // Output valid reloads from the reducer on every advance
  // With s2_valid low this empties the register after a handshake
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= s2_valid;
    end
  end

  // Only real results are loaded and a bubble leaves the old value in place
  always_ff @(posedge clk) begin
    if (advance && s2_valid) begin
      out_product <= product_d;
    end
  end

  // A stalled reducer must keep its sum and carry pair until the pipeline moves
  a_hold_sum: assert property (@(posedge clk) disable iff (!rst_n)
    s2_valid && !advance |=> s2_valid && $stable(sum) && $stable(carry));

endmodule

`default_nettype wire

/* booth4_multiplier.sv */
`timescale 1ns/10ps
`default_nettype none

module booth4_multiplier
  import mul_pkg::*;
#(
  parameter int MUL_SIZE = 32
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  logic [MUL_SIZE-1:0]   in_op1,
  input  logic [MUL_SIZE-1:0]   in_op2,
  input  mul_op_e               in_op,
  output logic                  in_ready,
  input  logic                  out_ready,
  output logic                  out_valid,
  output logic [2*MUL_SIZE-1:0] out_product
);

  localparam int PW   = 2 * MUL_SIZE;
  localparam int ROWS = booth_row_count(MUL_SIZE);
  localparam int CW   = booth_corr_width(MUL_SIZE);

  logic                advance;
  logic [MUL_SIZE-1:0] op1;
  logic [MUL_SIZE-1:0] op2;
  mul_sign_t           sign;
  logic                s1_valid;
  logic [PW-1:0]       pp [ROWS];
  logic [CW-1:0]       corr;
  logic [PW-1:0]       sum;
  logic [PW-1:0]       carry;
  logic                s2_valid;

  // A new request enters exactly when the whole pipeline advances
  assign in_ready = advance;

  // Stage 1 holds the request and its decoded sign flags
  mul_operand_stage #(.MUL_SIZE(MUL_SIZE)) i_operand_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance  (advance),
    .in_valid (in_valid),
    .in_op1   (in_op1),
    .in_op2   (in_op2),
    .in_op    (in_op),
    .op1      (op1),
    .op2      (op2),
    .sign     (sign),
    .s1_valid (s1_valid)
  );

  // Combinational recoding between stage 1 and stage 2
  booth4_op_generator #(.MUL_SIZE(MUL_SIZE)) i_op_generator (
    .op1  (op1),
    .op2  (op2),
    .sign (sign),
    .pp   (pp),
    .corr (corr)
  );

  // Stage 2 reduces all rows to a sum and carry pair
  csa_tree_reducer #(.MUL_SIZE(MUL_SIZE)) i_tree_reducer (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance  (advance),
    .s1_valid (s1_valid),
    .pp       (pp),
    .corr     (corr),
    .sum      (sum),
    .carry    (carry),
    .s2_valid (s2_valid)
  );

  // Stage 3 resolves the product and owns the stall decision
  mul_result_stage #(.MUL_SIZE(MUL_SIZE)) i_result_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .s2_valid    (s2_valid),
    .sum         (sum),
    .carry       (carry),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out_product (out_product),
    .advance     (advance)
  );

endmodule

`default_nettype wire

/* tb_booth4_multiplier.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_booth4_multiplier
  import mul_pkg::*;
();

  localparam int MUL_SIZE       = 16;
  localparam int PW             = 2 * MUL_SIZE;
  localparam int LATENCY        = 3;
  localparam int TIMEOUT_CYCLES = 4000;

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  logic [MUL_SIZE-1:0] in_op1;
  logic [MUL_SIZE-1:0] in_op2;
  mul_op_e             in_op;
  logic                in_ready;
  logic                out_ready = 1'b1;
  logic                out_valid;
  logic [PW-1:0]       out_product;

  // Expected products and acceptance cycles are queued in request order
  logic [PW-1:0] exp_q [$];
  int            accept_q [$];
  int            cycle_count  = 0;
  int            sent_count   = 0;
  int            result_count = 0;
  bit            check_latency;
  bit            random_ready;
  logic [31:0]   stim_state;
  logic [31:0]   ready_state = 32'd66 ^ 32'h9e3779b9;

  booth4_multiplier #(.MUL_SIZE(MUL_SIZE)) i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_op1      (in_op1),
    .in_op2      (in_op2),
    .in_op       (in_op),
    .in_ready    (in_ready),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out_product (out_product)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // One step of a 32-bit xorshift generator
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_stimulus();
    stim_state = xorshift32(stim_state);
    return stim_state;
  endfunction

  // Each operand is widened by its own sign rule, then the low half of the product is kept
  function automatic logic [PW-1:0] ref_product(input logic [MUL_SIZE-1:0] a,
                                                input logic [MUL_SIZE-1:0] b,
                                                input mul_op_e op);
    logic          a_signed;
    logic          b_signed;
    logic [PW-1:0] a_ext;
    logic [PW-1:0] b_ext;
    a_signed = (op == MUL_SS) || (op == MUL_SU);
    b_signed = (op == MUL_SS) || (op == MUL_US);
    a_ext = {{MUL_SIZE{a_signed & a[MUL_SIZE-1]}}, a};
    b_ext = {{MUL_SIZE{b_signed & b[MUL_SIZE-1]}}, b};
    return a_ext * b_ext;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "%s", what);
  endtask

  task automatic check_value(input string name, input logic [PW-1:0] actual,
                             input logic [PW-1:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("test failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // The cycle counter also guards against a hung pipeline
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("Timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES));
    end
  end

  // The consumer holds ready high or follows a random pattern
  // The mode is taken at the clock edge before any test task changes it
  always @(posedge clk) begin
    if (random_ready) begin
      #1;
      ready_state = xorshift32(ready_state);
      out_ready = ready_state[7];
    end else begin
      #1;
      out_ready = 1'b1;
    end
  end

  // Signals are stable at the falling edge, so a handshake seen here completes at the next rise
  always @(negedge clk) begin : monitor
    int accept_cycle;
    if (rst_n && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        report_failure("Output handshake with no request outstanding");
      end else begin
        accept_cycle = accept_q.pop_front();
        check_value("out_product", out_product, exp_q.pop_front());
        if (check_latency) begin
          check_value("latency", PW'(cycle_count - accept_cycle), PW'(LATENCY));
        end
        result_count++;
      end
    end
  end

  // Holds the request until in_ready is seen, then records its expected product
  task automatic send_request(input logic [MUL_SIZE-1:0] a, input logic [MUL_SIZE-1:0] b,
                              input mul_op_e op);
    bit accepted;
    accepted = 1'b0;
    in_valid = 1'b1;
    in_op1 = a;
    in_op2 = b;
    in_op = op;
    while (!accepted) begin
      @(negedge clk);
      if (in_ready) begin
        accepted = 1'b1;
        exp_q.push_back(ref_product(a, b, op));
        accept_q.push_back(cycle_count);
        sent_count++;
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    in_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Zero, one, all ones, alternating bits and the most negative value
  task automatic run_corner_set(input mul_op_e op);
    send_request(16'h0000, 16'hffff, op);
    send_request(16'h0001, 16'hffff, op);
    send_request(16'hffff, 16'hffff, op);
    send_request(16'haaaa, 16'h5555, op);
    send_request(16'h5555, 16'haaaa, op);
    send_request(16'h8000, 16'h8000, op);
    send_request(16'h8000, 16'h0001, op);
    send_request(16'h0001, 16'h8000, op);
    send_request(16'h7fff, 16'h8000, op);
    send_request(16'hffff, 16'h0001, op);
    wait_drain();
  endtask

  task automatic reset_state();
    @(negedge clk);
    check_value("out_valid", PW'(out_valid), PW'(1'b0));
    check_value("in_ready", PW'(in_ready), PW'(1'b1));
    @(posedge clk);
    #1;
  endtask

  task automatic unsigned_corners();
    check_value("ref_model", ref_product(16'hffff, 16'hffff, MUL_UU), 32'hfffe0001);
    run_corner_set(MUL_UU);
  endtask

  // The most negative operands produce the minus two digits and the largest correction
  task automatic signed_corners();
    check_value("ref_model", ref_product(16'h8000, 16'h8000, MUL_SS), 32'h40000000);
    check_value("ref_model", ref_product(16'hffff, 16'hffff, MUL_SS), 32'h00000001);
    check_value("ref_model", ref_product(16'h8000, 16'h0001, MUL_SS), 32'hffff8000);
    run_corner_set(MUL_SS);
  endtask

  task automatic mixed_signedness();
    check_value("ref_model", ref_product(16'h8000, 16'h0001, MUL_SU), 32'hffff8000);
    check_value("ref_model", ref_product(16'h8000, 16'h0001, MUL_US), 32'h00008000);
    run_corner_set(MUL_SU);
    run_corner_set(MUL_US);
  endtask

  // Back to back requests must be taken one per cycle with a fixed latency
  task automatic random_streaming();
    logic [31:0] r;
    logic [31:0] r_op;
    int          start_cycle;
    check_latency = 1'b1;
    start_cycle = cycle_count;
    repeat (200) begin
      r = next_stimulus();
      r_op = next_stimulus();
      send_request(r[15:0], r[31:16], mul_op_e'(r_op[1:0]));
    end
    check_value("stream_cycles", PW'(cycle_count - start_cycle), PW'(200));
    wait_drain();
    check_latency = 1'b0;
  endtask

  // Random consumer stalls and producer gaps must not lose or duplicate a result
  task automatic back_pressure();
    logic [31:0] r;
    logic [31:0] r_op;
    random_ready = 1'b1;
    repeat (100) begin
      r = next_stimulus();
      r_op = next_stimulus();
      send_request(r[15:0], r[31:16], mul_op_e'(r_op[1:0]));
      if (r_op[9]) begin
        in_valid = 1'b0;
        @(posedge clk);
        #1;
      end
    end
    wait_drain();
    random_ready = 1'b0;
    check_value("result_count", PW'(result_count), PW'(sent_count));
  endtask

  initial begin
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_op1 = '0;
    in_op2 = '0;
    in_op = MUL_UU;
    check_latency = 1'b0;
    random_ready = 1'b0;
    stim_state = 32'd66;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_state();
    unsigned_corners();
    signed_corners();
    mixed_signedness();
    random_streaming();
    back_pressure();
    if (exp_q.size() != 0 || sent_count != result_count) begin
      $display("Results missing at the end of the run: %0d outstanding", exp_q.size());
      $display("test failed");
      $fatal(1, "Outstanding results at end of run");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
mul_pkg.sv
mul_operand_stage.sv
booth4_op_generator.sv
csa_tree_reducer.sv
mul_result_stage.sv
booth4_multiplier.sv
tb_booth4_multiplier.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the multiplier testbench with Verilator and runs it
# The exit status of the simulation is the result of the run
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
  --timescale 1ns/10ps \
  --top-module tb_booth4_multiplier \
  -f vlog.f

./obj_dir/Vtb_booth4_multiplier
